/* me_lite.f */
me_lite_pkg.sv
me_lite_latency_timer.sv
me_lite_word_store.sv
me_lite_ctrl_fsm.sv
me_lite_tile.sv
me_lite_top.sv
me_lite_checker.sv
me_lite_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := me_lite_tb
FILELIST   := me_lite.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation failed
PASS_MSG   := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a verdict, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* me_lite_tb.sv */
module me_lite_tb
  import me_lite_pkg::*;
;

  localparam int num_pkts_lp        = 200;  // per tile
  localparam int zero_loads_lp      = 6;    // loads only, right after reset
  localparam int max_gap_lp         = 3;
  localparam int max_stall_lp       = 4;
  localparam int reset_cycles_lp    = 16;
  localparam int resp_latency_lp    = mem_latency_lp + 2;
  localparam int watchdog_lp =
    ((num_pkts_lp * (resp_latency_lp + max_gap_lp + max_stall_lp) * 8
      + reset_cycles_lp * 8) * 3) / 2;

  logic                         clk_i;
  logic                         arst_n_i;
  tr_pkt_t [num_tiles_lp-1:0]   tr_pkt_i;
  logic    [num_tiles_lp-1:0]   tr_pkt_v_i;
  logic    [num_tiles_lp-1:0]   tr_pkt_yumi_o;
  logic    [num_tiles_lp-1:0]   tr_pkt_ready_i;
  logic    [num_tiles_lp-1:0]   tr_pkt_v_o;
  tr_pkt_t [num_tiles_lp-1:0]   tr_pkt_o;

  word_data_t shadow [num_tiles_lp][store_words_lp];  // expected store contents
  int         cyc = 0;
  int         resp_total = 0;

  me_lite_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at time %0t: %s expected %0h, actual %0h",
                          $time, name, expected, actual));
    end
  endtask

  // applies one accepted packet to the shadow store and builds its response
  function automatic tr_pkt_t ref_response(int tile, tr_pkt_t pkt);
    logic [tr_op_width_lp-1:0] op;
    word_addr_t                addr;
    word_data_t                data;
    op   = pkt[tr_op_lsb_lp+:tr_op_width_lp];
    addr = pkt[tr_addr_lsb_lp+:addr_width_lp];
    data = pkt[0+:data_width_lp];
    if (op == e_tr_store) begin
      shadow[tile][addr] = data;
    end else begin
      data = shadow[tile][addr];  // load and the two unused codes
    end
    return {op, addr, data};
  endfunction

  for (genvar t = 0; t < num_tiles_lp; t++) begin : g_port
    tr_pkt_t pkt_d;
    logic    v_d;
    logic    rdy_d;
    tr_pkt_t exp_q [$];
    int      acc_edge = 0;

    assign tr_pkt_i[t]       = pkt_d;
    assign tr_pkt_v_i[t]     = v_d;
    assign tr_pkt_ready_i[t] = rdy_d;

    initial begin : drive
      int                        gap;
      logic [tr_op_width_lp-1:0] op;
      word_addr_t                addr;
      word_data_t                data;
      pkt_d = '0;
      v_d   = 1'b0;
      wait (arst_n_i);
      @(posedge clk_i);
      for (int n = 0; n < num_pkts_lp; n++) begin
        gap  = $urandom_range(0, max_gap_lp);
        op   = tr_op_width_lp'($urandom_range(0, 3));
        addr = word_addr_t'($urandom_range(0, store_words_lp - 1));
        data = $urandom;
        if (n < zero_loads_lp && op == e_tr_store) begin
          op = e_tr_load;
        end
        if (gap > 0) begin
          #1 v_d = 1'b0;
          repeat (gap) @(posedge clk_i);
        end
        #1;
        pkt_d = {op, addr, data};
        v_d   = 1'b1;
        @(negedge clk_i);
        while (!tr_pkt_yumi_o[t]) @(negedge clk_i);
        exp_q.push_back(ref_response(t, pkt_d));
        acc_edge = cyc + 1;  // yumi edge is the next rising edge
        @(posedge clk_i);
      end
      #1 v_d = 1'b0;
    end

    // ready runs high for 1 to 4 cycles, then low for up to max_stall_lp
    initial begin : ready_pattern
      int hi;
      int lo;
      rdy_d = 1'b0;
      wait (arst_n_i);
      forever begin
        hi    = $urandom_range(1, 4);
        lo    = $urandom_range(0, max_stall_lp);
        rdy_d = 1'b1;
        repeat (hi) begin
          @(posedge clk_i);
          #1;
        end
        rdy_d = 1'b0;
        repeat (lo) begin
          @(posedge clk_i);
          #1;
        end
      end
    end

    initial begin : compare
      tr_pkt_t expected;
      tr_pkt_t got;
      logic    v_prev;
      v_prev = 1'b0;
      forever begin
        @(negedge clk_i);
        if (tr_pkt_v_o[t] && !v_prev) begin
          check_value($sformatf("tr_pkt_v_o[%0d] latency", t), resp_latency_lp, cyc - acc_edge);
        end
        v_prev = tr_pkt_v_o[t];
        if (tr_pkt_v_o[t] && rdy_d) begin  // transfer at the coming edge
          got = tr_pkt_o[t];
          if (exp_q.size() == 0) begin
            abort_run($sformatf("tile %0d returned a response with no request pending", t));
          end
          expected = exp_q.pop_front();
          check_value($sformatf("tr_pkt_o[%0d]", t), expected, got);
          resp_total++;
        end
      end
    end
  end : g_port

  initial begin : watchdog
    #(watchdog_lp);
    abort_run("watchdog expired, responses stopped arriving");
  end

  initial begin : assert_watch
    wait (UUT.handshake_chk.fail_cnt != 0);
    abort_run("a handshake assertion in the bound checker failed");
  end

  initial begin
    void'($urandom(21065));
    for (int i = 0; i < num_tiles_lp; i++) begin
      for (int w = 0; w < store_words_lp; w++) begin
        shadow[i][w] = '0;
      end
    end
    arst_n_i = 1'b0;
    repeat (reset_cycles_lp) @(posedge clk_i);
    #1 arst_n_i = 1'b1;
    wait (resp_total == num_tiles_lp * num_pkts_lp);
    repeat (4) @(posedge clk_i);  // let the last handshakes settle
    if (UUT.handshake_chk.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : me_lite_tb

/* me_lite_checker.sv */
module me_lite_checker
  import me_lite_pkg::*;
(
  input                              clk_i,
  input                              arst_n_i,
  input  logic    [num_tiles_lp-1:0] tr_pkt_v_i,
  input  logic    [num_tiles_lp-1:0] tr_pkt_yumi_o,
  input  logic    [num_tiles_lp-1:0] tr_pkt_ready_i,
  input  logic    [num_tiles_lp-1:0] tr_pkt_v_o,
  input  tr_pkt_t [num_tiles_lp-1:0] tr_pkt_o
);

  int fail_cnt = 0;

  for (genvar i = 0; i < num_tiles_lp; i++) begin : g_chk
    // response held under back-pressure
    a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tr_pkt_v_o[i] && !tr_pkt_ready_i[i] |=> tr_pkt_v_o[i] && $stable(tr_pkt_o[i]))
      else begin
        fail_cnt++;
        $error("tile %0d response dropped or changed while ready was low", i);
      end

    a_yumi_v: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(tr_pkt_yumi_o[i] && !tr_pkt_v_i[i]))
      else begin
        fail_cnt++;
        $error("tile %0d yumi without valid input", i);
      end

    a_yumi_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(tr_pkt_yumi_o[i] && tr_pkt_v_o[i]))
      else begin
        fail_cnt++;
        $error("tile %0d accepted a packet while a response was pending", i);
      end
  end : g_chk

endmodule : me_lite_checker

bind me_lite_top me_lite_checker handshake_chk (.*);

/* me_lite_top.sv */
module me_lite_top
  import me_lite_pkg::*;
(
  input                                clk_i,
  input                                arst_n_i,

  // trace replay ports, one entry per tile
  input  tr_pkt_t [num_tiles_lp-1:0]   tr_pkt_i,
  input  logic    [num_tiles_lp-1:0]   tr_pkt_v_i,
  output logic    [num_tiles_lp-1:0]   tr_pkt_yumi_o,

  input  logic    [num_tiles_lp-1:0]   tr_pkt_ready_i,
  output logic    [num_tiles_lp-1:0]   tr_pkt_v_o,
  output tr_pkt_t [num_tiles_lp-1:0]   tr_pkt_o
);

  // tiles share nothing but clock and reset
  for (genvar i = 0; i < num_tiles_lp; i++) begin : g_tile
    me_lite_tile tile (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .tr_pkt_i       (tr_pkt_i[i]),
      .tr_pkt_v_i     (tr_pkt_v_i[i]),
      .tr_pkt_yumi_o  (tr_pkt_yumi_o[i]),
      .tr_pkt_ready_i (tr_pkt_ready_i[i]),
      .tr_pkt_v_o     (tr_pkt_v_o[i]),
      .tr_pkt_o       (tr_pkt_o[i])
    );
  end : g_tile

endmodule : me_lite_top

/* me_lite_tile.sv */
module me_lite_tile
  import me_lite_pkg::*;
(
  input           clk_i,
  input           arst_n_i,

  input  tr_pkt_t tr_pkt_i,
  input           tr_pkt_v_i,
  output logic    tr_pkt_yumi_o,

  input           tr_pkt_ready_i,
  output logic    tr_pkt_v_o,
  output tr_pkt_t tr_pkt_o
);

  logic       timer_start;
  logic       timer_done;
  logic       store_en;
  logic       store_we;
  word_addr_t store_addr;
  word_data_t store_wdata;
  word_data_t store_rdata;

  me_lite_ctrl_fsm fsm (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .tr_pkt_i       (tr_pkt_i),
    .tr_pkt_v_i     (tr_pkt_v_i),
    .tr_pkt_yumi_o  (tr_pkt_yumi_o),
    .tr_pkt_ready_i (tr_pkt_ready_i),
    .tr_pkt_v_o     (tr_pkt_v_o),
    .tr_pkt_o       (tr_pkt_o),
    .timer_start_o  (timer_start),
    .timer_done_i   (timer_done),
    .store_en_o     (store_en),
    .store_we_o     (store_we),
    .store_addr_o   (store_addr),
    .store_wdata_o  (store_wdata),
    .store_rdata_i  (store_rdata)
  );

  me_lite_latency_timer timer (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .start_i  (timer_start),
    .done_o   (timer_done)
  );

  me_lite_word_store store (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .en_i     (store_en),
    .we_i     (store_we),
    .addr_i   (store_addr),
    .wdata_i  (store_wdata),
    .rdata_o  (store_rdata)
  );

endmodule : me_lite_tile

/* me_lite_ctrl_fsm.sv */
module me_lite_ctrl_fsm
  import me_lite_pkg::*;
(
  input               clk_i,
  input               arst_n_i,

  // trace input, v/yumi
  input  tr_pkt_t     tr_pkt_i,
  input               tr_pkt_v_i,
  output logic        tr_pkt_yumi_o,

  // trace output, v/ready
  input               tr_pkt_ready_i,
  output logic        tr_pkt_v_o,
  output tr_pkt_t     tr_pkt_o,

  // latency timer
  output logic        timer_start_o,
  input               timer_done_i,

  // word store
  output logic        store_en_o,
  output logic        store_we_o,
  output word_addr_t  store_addr_o,
  output word_data_t  store_wdata_o,
  input  word_data_t  store_rdata_i
);

  ctrl_state_e state_r, state_n;

  logic [tr_op_width_lp-1:0] op_r;
  word_addr_t                addr_r;
  word_data_t                data_r;
  logic                      start_r;

  assign tr_pkt_yumi_o = (state_r == e_idle) && tr_pkt_v_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: begin
        if (tr_pkt_v_i) begin
          state_n = e_wait;
        end
      end
      e_wait: begin
        if (timer_done_i) begin
          state_n = e_access;
        end
      end
      e_access: state_n = e_resp;  // read word lands at this edge
      e_resp: begin
        if (tr_pkt_ready_i) begin
          state_n = e_idle;
        end
      end
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= e_idle;
      start_r <= 1'b0;
    end else begin
      state_r <= state_n;
      start_r <= tr_pkt_yumi_o;  // first e_wait cycle
    end
  end

  // request fields, taken on the yumi edge
  always_ff @(posedge clk_i) begin
    if (tr_pkt_yumi_o) begin
      op_r   <= tr_pkt_i[tr_op_lsb_lp+:tr_op_width_lp];
      addr_r <= tr_pkt_i[tr_addr_lsb_lp+:addr_width_lp];
      data_r <= tr_pkt_i[0+:data_width_lp];
    end
  end

  assign timer_start_o = start_r;

  assign store_en_o    = (state_r == e_access);
  assign store_we_o    = store_en_o && (op_r == e_tr_store);  // other codes read
  assign store_addr_o  = addr_r;
  assign store_wdata_o = data_r;

  // store is idle in e_resp so the read word stays put
  assign tr_pkt_v_o = (state_r == e_resp);
  assign tr_pkt_o   = {op_r, addr_r, store_rdata_i};

endmodule : me_lite_ctrl_fsm

/* me_lite_word_store.sv */
module me_lite_word_store
  import me_lite_pkg::*;
(
  input              clk_i,
  input              arst_n_i,
  input              en_i,
  input              we_i,
  input  word_addr_t addr_i,
  input  word_data_t wdata_i,
  output word_data_t rdata_o
);

  word_data_t mem_r [store_words_lp];

  // whole array is cleared on reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < store_words_lp; i++) begin
        mem_r[i] <= '0;
      end
    end else if (en_i && we_i) begin
      mem_r[addr_i] <= wdata_i;
    end
  end

  // read word register, a store returns the written word
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        rdata_o <= wdata_i;
      end else begin
        rdata_o <= mem_r[addr_i];
      end
    end
  end

endmodule : me_lite_word_store

/* me_lite_latency_timer.sv */
module me_lite_latency_timer
  import me_lite_pkg::*;
(
  input        clk_i,
  input        arst_n_i,
  input        start_i,
  output logic done_o
);

  localparam logic [timer_width_lp-1:0] load_val_lp = timer_width_lp'(mem_latency_lp - 1);

  logic [timer_width_lp-1:0] cnt_r;
  logic                      busy_r;

  // a start seen while busy is ignored
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_r  <= '0;
      busy_r <= 1'b0;
    end else if (start_i && !busy_r) begin
      cnt_r  <= load_val_lp;
      busy_r <= 1'b1;
    end else if (busy_r) begin
      if (cnt_r == '0) begin
        busy_r <= 1'b0;  // expired, back to idle
      end else begin
        cnt_r <= cnt_r - 1'b1;
      end
    end
  end

  assign done_o = busy_r && (cnt_r == '0);  // one cycle, last busy cycle

endmodule : me_lite_latency_timer

/* me_lite_pkg.sv */
package me_lite_pkg;

  localparam int num_tiles_lp   = 2;
  localparam int addr_width_lp  = 4;
  localparam int data_width_lp  = 32;
  localparam int store_words_lp = 16;

  localparam int mem_latency_lp = 4;  // cycles from timer start to done
  localparam int timer_width_lp = 3;

  // trace packet layout, msb first: opcode | address | data
  localparam int tr_op_width_lp   = 2;
  localparam int tr_addr_lsb_lp   = data_width_lp;
  localparam int tr_op_lsb_lp     = tr_addr_lsb_lp + addr_width_lp;
  localparam int tr_pkt_width_lp  = tr_op_lsb_lp + tr_op_width_lp;

  typedef logic [addr_width_lp-1:0]    word_addr_t;
  typedef logic [data_width_lp-1:0]    word_data_t;
  typedef logic [tr_pkt_width_lp-1:0]  tr_pkt_t;

  // codes 2 and 3 are not used and fall back to load
  typedef enum logic [tr_op_width_lp-1:0] {
    e_tr_load  = 2'b00,
    e_tr_store = 2'b01
  } tr_opcode_e;

  typedef enum logic [1:0] {
    e_idle   = 2'b00,
    e_wait   = 2'b01,  // memory latency
    e_access = 2'b10,
    e_resp   = 2'b11   // result held until ready
  } ctrl_state_e;

endpackage : me_lite_pkg
